// File: rv_settings.svh
// rv32i core settings
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path width
`define RV_XLEN 32

// architectural registers
`define RV_REG_COUNT 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64

// first fetch address, indexes the instruction array directly
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
// rv32i shared types
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [$clog2(`RV_DMEM_WORDS)-1:0] dmem_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no operands, unsupported opcode
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic {
        FETCH,
        EXEC
    } fetch_state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        inst_type_t inst_type;
        alu_op_t    alu_op;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rd_wdata;
        word_t    next_pc;
    } retire_t;

endpackage

// File: alu.sv
// integer alu
`timescale 1ns/1ns
`include "rv_settings.svh"

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];  // low bits of b only

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = rv_pkg::word_t'($signed(a) < $signed(b));
            rv_pkg::ALU_SLTU: result = rv_pkg::word_t'(a < b);
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;  // sign fill
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

// File: reg_file.sv
// integer register file
`timescale 1ns/1ns
`include "rv_settings.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // combinational read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: decoder.sv
// rv32i instruction decoder
`timescale 1ns/1ns

module decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t decoded
);

    rv_pkg::opcode_t    opcode;
    rv_pkg::inst_type_t inst_type;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::word_t      imm;
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign opcode = rv_pkg::opcode_t'(inst[6:0]);  // may hold a non-member code
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // format from the major opcode
    always_comb begin
        case (opcode)
            rv_pkg::OP:                             inst_type = rv_pkg::TYPE_R;
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR: inst_type = rv_pkg::TYPE_I;
            rv_pkg::STORE:                          inst_type = rv_pkg::TYPE_S;
            rv_pkg::BRANCH:                         inst_type = rv_pkg::TYPE_B;
            rv_pkg::LUI, rv_pkg::AUIPC:             inst_type = rv_pkg::TYPE_U;
            rv_pkg::JAL:                            inst_type = rv_pkg::TYPE_J;
            default:                                inst_type = rv_pkg::TYPE_N;
        endcase
    end

    // sign-extended immediates
    always_comb begin
        case (inst_type)
            rv_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::TYPE_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::TYPE_B: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::TYPE_U: imm = {inst[31:12], 12'b0};
            rv_pkg::TYPE_J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:        imm = '0;
        endcase
    end

    // everything but OP and OP_IMM computes an address or sum with add
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OP || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (inst_type == rv_pkg::TYPE_R && funct7[5]) begin
                        alu_op = rv_pkg::ALU_SUB;  // addi has no subtract form
                    end
                end
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                3'b111:  alu_op = rv_pkg::ALU_AND;
                default: alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

    assign decoded = '{
        opcode:    opcode,
        funct3:    funct3,
        rd:        inst[11:7],
        rs1:       inst[19:15],
        rs2:       inst[24:20],
        imm:       imm,
        inst_type: inst_type,
        alu_op:    alu_op
    };

endmodule

// File: fetch_unit.sv
// instruction fetch
`timescale 1ns/1ns
`include "rv_settings.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    input  logic               jump_en,
    input  rv_pkg::word_t      jump_target,
    output rv_pkg::word_t      inst,
    output rv_pkg::word_t      pc,
    output logic               inst_valid
);

    rv_pkg::word_t        imem [`RV_IMEM_WORDS];
    rv_pkg::fetch_state_t state;
    rv_pkg::imem_addr_t   fetch_addr;

    // load port used while the core is stopped
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign fetch_addr = pc[$bits(rv_pkg::imem_addr_t)+1:2];  // word index

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::FETCH;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                rv_pkg::FETCH: begin
                    if (run) begin
                        state <= rv_pkg::EXEC;
                    end
                end
                rv_pkg::EXEC: begin
                    state <= rv_pkg::FETCH;
                    pc    <= jump_en ? jump_target : pc + 32'd4;  // retire edge
                end
                default: state <= rv_pkg::FETCH;
            endcase
        end
    end

    // fetched word held for the EXEC cycle
    always_ff @(posedge clk) begin
        if (state == rv_pkg::FETCH && run) begin
            inst <= imem[fetch_addr];
        end
    end

    assign inst_valid = (state == rv_pkg::EXEC);

    // instruction array only rewritten while fetching is stopped
    assert property (@(posedge clk) disable iff (reset) imem_we |-> !run);

endmodule

// File: execute_unit.sv
// execute, memory access and write-back
`timescale 1ns/1ns
`include "rv_settings.svh"

module execute_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::decoded_t decoded,
    output logic             jump_en,
    output rv_pkg::word_t    jump_target,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire
);

    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    rv_pkg::word_t      alu_a;
    rv_pkg::word_t      alu_b;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      load_data;
    rv_pkg::word_t      rd_wdata;
    rv_pkg::word_t      pc_plus4;
    rv_pkg::word_t      next_pc;
    rv_pkg::word_t      dmem [`RV_DMEM_WORDS];
    rv_pkg::dmem_addr_t dmem_addr;
    logic               rd_we;
    logic               dmem_we;
    logic               is_word;
    logic               branch_taken;

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we && inst_valid),
        .waddr  (decoded.rd),
        .wdata  (rd_wdata),
        .raddr1 (decoded.rs1),
        .raddr2 (decoded.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (decoded.alu_op),
        .result (alu_result)
    );

    assign pc_plus4 = pc + 32'd4;
    assign is_word  = (decoded.funct3 == 3'b010);  // only LW and SW are kept

    // operand select by format
    always_comb begin
        alu_a = rs1_data;
        alu_b = decoded.imm;
        case (decoded.inst_type)
            rv_pkg::TYPE_R:                 alu_b = rs2_data;
            rv_pkg::TYPE_U:                 alu_a = (decoded.opcode == rv_pkg::LUI) ? '0 : pc;
            rv_pkg::TYPE_B, rv_pkg::TYPE_J: alu_a = pc;  // target pc + imm
            default: ;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        case (decoded.opcode)
            rv_pkg::JAL:    jump_en = 1'b1;
            rv_pkg::JALR: begin
                jump_en     = 1'b1;
                jump_target = alu_result & ~rv_pkg::word_t'(1);  // clear bit 0
            end
            rv_pkg::BRANCH: jump_en = branch_taken;
            default: ;
        endcase
    end

    assign next_pc = jump_en ? jump_target : pc_plus4;

    // word data memory at the alu sum
    assign dmem_addr = alu_result[$bits(rv_pkg::dmem_addr_t)+1:2];
    assign load_data = dmem[dmem_addr];
    assign dmem_we   = inst_valid && decoded.opcode == rv_pkg::STORE && is_word;

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= rs2_data;
        end
    end

    // write-back select
    always_comb begin
        rd_we    = 1'b0;
        rd_wdata = alu_result;
        case (decoded.opcode)
            rv_pkg::OP, rv_pkg::OP_IMM, rv_pkg::LUI, rv_pkg::AUIPC: rd_we = 1'b1;
            rv_pkg::LOAD: begin
                rd_we    = is_word;
                rd_wdata = load_data;
            end
            rv_pkg::JAL, rv_pkg::JALR: begin
                rd_we    = 1'b1;
                rd_wdata = pc_plus4;  // link address
            end
            default: ;  // branches, stores, unsupported
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= inst_valid;  // one cycle after EXEC
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire <= '{
                pc:       pc,
                rd:       decoded.rd,
                rd_we:    rd_we,
                rd_wdata: rd_wdata,
                next_pc:  next_pc
            };
        end
    end

    // redirect seen by the fetch unit must land on a word boundary
    assert property (@(posedge clk) disable iff (reset)
        (inst_valid && jump_en) |-> (jump_target[1:0] == 2'b00));

endmodule

// File: rv_core.sv
// rv32i core top level
`timescale 1ns/1ns

module rv_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    output logic               retire_valid,
    output rv_pkg::retire_t    retire
);

    rv_pkg::word_t    inst;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    jump_target;
    rv_pkg::decoded_t decoded;
    logic             inst_valid;
    logic             jump_en;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .inst        (inst),
        .pc          (pc),
        .inst_valid  (inst_valid)
    );

    decoder u_decoder (
        .inst    (inst),
        .decoded (decoded)
    );

    execute_unit u_execute_unit (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .pc           (pc),
        .decoded      (decoded),
        .jump_en      (jump_en),
        .jump_target  (jump_target),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: tb_rv_core.sv
// rv32i core testbench
`timescale 1ns/1ns
`include "rv_settings.svh"

module tb_rv_core;

    // six tests of 3 reset, 64 load and under 30 two-cycle retires come to about 800 cycles
    localparam int MAX_CYCLES  = 2000;
    localparam int RETIRE_WAIT = 8;

    logic               clk;
    logic               reset;
    logic               run;
    logic               imem_we;
    rv_pkg::imem_addr_t imem_addr;
    rv_pkg::word_t      imem_wdata;
    logic               retire_valid;
    rv_pkg::retire_t    retire;

    rv_pkg::word_t prog [`RV_IMEM_WORDS];
    rv_pkg::word_t exp_pc;
    rv_pkg::word_t lfsr_state = 32'h4b80;
    string         cur_test;
    int            test_errors;
    int            tests_passed;
    int            tests_failed;
    int            cycles;

    rv_core u_dut (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, cycle limit of %0d reached", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // taps 32 22 2 1 stepped once per bit taken
    function automatic rv_pkg::word_t rand_bits(input int nbits);
        rv_pkg::word_t v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::JAL};
    endfunction

    // integer op by funct3 where alt selects the funct7 bit 5 form
    function automatic rv_pkg::word_t alu_expect(input logic [2:0] f3, input logic alt,
                                                 input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_expect(input logic [2:0] f3, input rv_pkg::word_t a,
                                           input rv_pkg::word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare(input string field, input rv_pkg::word_t expected,
                           input rv_pkg::word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            prog[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM);  // x0 += index
        end
    endtask

    // reset, load the whole array, then let the core run
    task automatic start_program();
        reset = 1'b1;
        run   = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            imem_we    = 1'b1;
            imem_addr  = rv_pkg::imem_addr_t'(i);
            imem_wdata = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        run     = 1'b1;
        exp_pc  = `RV_RESET_PC;
    endtask

    task automatic end_test();
        run = 1'b0;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic expect_retire(input logic we, input logic [4:0] rd,
                                 input rv_pkg::word_t wdata, input rv_pkg::word_t next_pc);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!retire_valid && waited < RETIRE_WAIT);
        if (!retire_valid) begin
            $display("test %s waited %0d cycles for a retire that never came", cur_test, waited);
            test_errors++;
        end else begin
            compare("pc", exp_pc, retire.pc);
            compare("rd_we", rv_pkg::word_t'(we), rv_pkg::word_t'(retire.rd_we));
            if (we) begin
                compare("rd", rv_pkg::word_t'(rd), rv_pkg::word_t'(retire.rd));
                compare("rd_wdata", wdata, retire.rd_wdata);
            end
            compare("next_pc", next_pc, retire.next_pc);
        end
        exp_pc = next_pc;
    endtask

    task automatic expect_seq(input logic we, input logic [4:0] rd, input rv_pkg::word_t wdata);
        expect_retire(we, rd, wdata, exp_pc + 32'd4);
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task automatic put_const(inout int idx, input logic [4:0] rd, input rv_pkg::word_t value);
        rv_pkg::word_t hi;
        hi            = (value + 32'h800) >> 12;
        prog[idx]     = enc_u(hi[19:0], rd, rv_pkg::LUI);
        prog[idx + 1] = enc_i(value[11:0], rd, 3'd0, rd, rv_pkg::OP_IMM);
        idx += 2;
    endtask

    task automatic expect_const(input logic [4:0] rd, input rv_pkg::word_t value);
        rv_pkg::word_t hi;
        hi = (value + 32'h800) >> 12;
        expect_seq(1'b1, rd, {hi[19:0], 12'b0});
        expect_seq(1'b1, rd, value);
    endtask

    task automatic test_alu_ops();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        logic [11:0]   i_imm [9];
        logic [2:0]    f3;
        int            idx;
        begin_test("alu_ops");
        a   = rand_bits(32);
        b   = rand_bits(32);
        idx = 0;
        put_const(idx, 5'd1, a);
        put_const(idx, 5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            prog[idx] = enc_r((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3);
            idx++;
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5;
            if (k == 1 || k == 5) begin
                i_imm[k] = {7'h00, 5'(rand_bits(5))};
            end else if (k == 8) begin
                i_imm[k] = {7'h20, 5'(rand_bits(5))};  // srai
            end else begin
                i_imm[k] = rand_bits(12);
            end
            prog[idx] = enc_i(i_imm[k], 5'd1, f3, 5'd4, rv_pkg::OP_IMM);
            idx++;
        end
        start_program();
        expect_const(5'd1, a);
        expect_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            expect_seq(1'b1, 5'd3, alu_expect(f3, k >= 8, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5;
            expect_seq(1'b1, 5'd4, alu_expect(f3, f3 == 3'd5 && i_imm[k][10], a,
                                              {{20{i_imm[k][11]}}, i_imm[k]}));
        end
        end_test();
    endtask

    task automatic test_x0();
        begin_test("x0");
        prog[0] = enc_i(12'd5, 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM);
        prog[1] = enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5);
        start_program();
        expect_seq(1'b1, 5'd0, 32'd5);
        expect_seq(1'b1, 5'd5, 32'd0);  // x0 kept its zero
        end_test();
    endtask

    task automatic test_upper_imm();
        logic [19:0] u1;
        logic [19:0] u2;
        begin_test("upper_imm");
        u1      = rand_bits(20);
        u2      = rand_bits(20);
        prog[0] = enc_u(u1, 5'd7, rv_pkg::LUI);
        prog[1] = enc_u(u2, 5'd8, rv_pkg::AUIPC);
        start_program();
        expect_seq(1'b1, 5'd7, {u1, 12'b0});
        expect_seq(1'b1, 5'd8, exp_pc + {u2, 12'b0});
        end_test();
    endtask

    task automatic test_branches();
        int            br_f3 [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int            br_rs1 [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
        int            br_rs2 [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
        rv_pkg::word_t vals [4] = '{32'd0, -32'sd5, 32'd3, -32'sd5};
        logic          taken;
        begin_test("branches");
        for (int r = 1; r < 4; r++) begin
            prog[r - 1] = enc_i(vals[r][11:0], 5'd0, 3'd0, 5'(r), rv_pkg::OP_IMM);
        end
        for (int k = 0; k < 12; k++) begin
            prog[3 + 2 * k] = enc_b(13'd8, 5'(br_rs2[k]), 5'(br_rs1[k]), 3'(br_f3[k]));
        end
        start_program();
        for (int r = 1; r < 4; r++) begin
            expect_seq(1'b1, 5'(r), vals[r]);
        end
        for (int k = 0; k < 12; k++) begin
            taken = branch_expect(3'(br_f3[k]), vals[br_rs1[k]], vals[br_rs2[k]]);
            expect_retire(1'b0, 5'd0, '0, taken ? exp_pc + 32'd8 : exp_pc + 32'd4);
            if (!taken) begin
                expect_seq(1'b1, 5'd0, exp_pc >> 2);  // fill word after a fall-through
            end
        end
        end_test();
    endtask

    task automatic test_jumps();
        begin_test("jumps");
        prog[0] = enc_i(12'd33, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM);
        prog[1] = enc_j(21'd12, 5'd5);
        prog[4] = enc_i(12'd4, 5'd1, 3'd0, 5'd6, rv_pkg::JALR);  // odd sum loses bit 0
        prog[9] = enc_i(12'd7, 5'd0, 3'd0, 5'd7, rv_pkg::OP_IMM);
        start_program();
        expect_seq(1'b1, 5'd1, 32'd33);
        expect_retire(1'b1, 5'd5, exp_pc + 32'd4, exp_pc + 32'd12);
        expect_retire(1'b1, 5'd6, exp_pc + 32'd4, (32'd33 + 32'd4) & ~32'd1);
        expect_seq(1'b1, 5'd7, 32'd7);
        end_test();
    endtask

    task automatic test_memory();
        rv_pkg::word_t w;
        int            idx;
        begin_test("memory");
        w   = rand_bits(32);
        idx = 0;
        put_const(idx, 5'd1, w);
        prog[2] = enc_i(12'd64, 5'd0, 3'd0, 5'd2, rv_pkg::OP_IMM);
        prog[3] = enc_s(12'd8, 5'd1, 5'd2, 3'b010);
        prog[4] = enc_i(12'd8, 5'd2, 3'b010, 5'd3, rv_pkg::LOAD);
        prog[5] = enc_i(12'd0, 5'd0, 3'd0, 5'd4, 7'b1110011);  // system opcode, not kept
        start_program();
        expect_const(5'd1, w);
        expect_seq(1'b1, 5'd2, 32'd64);
        expect_seq(1'b0, 5'd0, '0);
        expect_seq(1'b1, 5'd3, w);
        expect_seq(1'b0, 5'd0, '0);
        end_test();
    endtask

    initial begin
        reset        = 1'b1;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        cycles       = 0;
        tests_passed = 0;
        tests_failed = 0;
        @(negedge clk);
        test_alu_ops();
        test_x0();
        test_upper_imm();
        test_branches();
        test_jumps();
        test_memory();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
rv_pkg.sv
alu.sv
reg_file.sv
decoder.sv
fetch_unit.sv
execute_unit.sv
rv_core.sv
tb_rv_core.sv
